/* hdl/tile_defines.svh */
// Widths, master count, memory sizes and region codes of the compute tile; include where needed
`ifndef TILE_DEFINES_SVH
`define TILE_DEFINES_SVH

// Wishbone data path
`define TILE_ADDR_W 32
`define TILE_DATA_W 32
`define TILE_SEL_W 4

// Instruction and data port of the removed core
`define TILE_MASTERS 2

// Local data memory depth in words, aliased over the whole lower half
`define TILE_LMEM_WORDS 256

// Boot image depth in words
`define TILE_BOOT_WORDS 16

// Top address nibble that selects the boot ROM
`define TILE_REGION_BOOT 4'hf

`endif

/* hdl/boot_rom_image.svh */
// Boot image as an array literal macro; the boot ROM and the testbench model both build tables from it
`ifndef BOOT_ROM_IMAGE_SVH
`define BOOT_ROM_IMAGE_SVH

// Sets up the stack in local memory, clears a few registers and jumps to address 0x100.
// The tail is padding with no-ops so that the table fills all 16 words.
`define BOOT_IMAGE '{ \
   32'h18200000, 32'ha82103fc, 32'h18600000, 32'ha8630100, \
   32'he0800004, 32'he0a00004, 32'he0c00004, 32'he0e00004, \
   32'h44001800, 32'h15000000, 32'h15000000, 32'h15000000, \
   32'h15000000, 32'h15000000, 32'h15000000, 32'h00000000  \
}

`endif

/* hdl/tile_pkg.sv */
// Bus request, response, address and snoop types shared by all tile modules through a wildcard import
`include "tile_defines.svh"

package tile_pkg;

   // One address word, seen either as a byte address or as region plus offset
   typedef union packed {
      logic [`TILE_ADDR_W-1:0] raw;      // Byte address, memories index by word
      struct packed {
         logic [3:0]               region; // Top nibble used by the decoder
         logic [`TILE_ADDR_W-5:0]  offset;
      } view;
   } bus_addr_u;

   typedef struct packed {
      logic                    cyc;
      logic                    stb;
      logic                    we;
      logic [`TILE_SEL_W-1:0]  sel;  // Byte enables
      bus_addr_u               adr;
      logic [`TILE_DATA_W-1:0] dat;  // Write data
   } wb_req_t;

   typedef struct packed {
      logic                    ack;
      logic                    err;
      logic [`TILE_DATA_W-1:0] dat;  // Read data, valid with ack
   } wb_rsp_t;

   typedef struct packed {
      logic                    valid; // One cycle per data memory write
      logic [`TILE_ADDR_W-1:0] adr;
   } snoop_t;

   typedef enum logic [1:0] {
      SLV_DM,
      SLV_BOOT,
      SLV_NONE
   } slave_sel_e;

endpackage

/* hdl/wb_arbiter.sv */
// Round-robin Wishbone arbiter that hands the shared tile bus to one master at a time
`include "tile_defines.svh"

module wb_arbiter
   import tile_pkg::*;
#(
   parameter int MASTERS = `TILE_MASTERS
) (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  wb_req_t [MASTERS-1:0]  m_req_i,
   output wb_rsp_t [MASTERS-1:0]  m_rsp_o,
   output wb_req_t                bus_req_o,
   input  wb_rsp_t                bus_rsp_i
);

   localparam int IDX_W = (MASTERS > 1) ? $clog2(MASTERS) : 1;

   logic [IDX_W-1:0] owner_q;  // Master holding the bus
   logic             owned_q;  // Bus currently taken
   logic [IDX_W-1:0] last_q;   // Previous owner, search starts after it
   logic [IDX_W-1:0] pick;
   logic             pick_vld;

   // Search the masters in order, starting after the last owner
   always_comb begin
      int idx;
      pick     = last_q;
      pick_vld = 1'b0;
      for (int k = 1; k <= MASTERS; k++) begin
         idx = (int'(last_q) + k) % MASTERS;
         if (!pick_vld && m_req_i[idx].cyc) begin
            pick     = IDX_W'(idx);
            pick_vld = 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         owned_q <= 1'b0;
         owner_q <= '0;
         last_q  <= IDX_W'(MASTERS - 1); // Master 0 wins first
      end else if (!owned_q) begin
         if (pick_vld) begin
            owned_q <= 1'b1;
            owner_q <= pick;
            last_q  <= pick;
         end
      end else if (!m_req_i[owner_q].cyc) begin
         owned_q <= 1'b0;                // Owner finished its cycle
      end
   end

   // Idle bus when nobody owns it
   assign bus_req_o = owned_q ? m_req_i[owner_q] : '0;

   always_comb begin
      for (int m = 0; m < MASTERS; m++) begin
         m_rsp_o[m].dat = bus_rsp_i.dat;   // Data is shared, strobes are not
         m_rsp_o[m].ack = bus_rsp_i.ack && owned_q && (owner_q == IDX_W'(m));
         m_rsp_o[m].err = bus_rsp_i.err && owned_q && (owner_q == IDX_W'(m));
      end
   end

   // A master only sees ack after it has owned the bus for the whole access
   for (genvar g = 0; g < MASTERS; g++) begin : gen_ack_chk
      a_ack_owner : assert property (@(posedge clk_i) disable iff (!rst_n_i)
         m_rsp_o[g].ack |-> (owner_q == IDX_W'(g)) && $past(owned_q && owner_q == IDX_W'(g)));
   end

endmodule

/* hdl/wb_slave_decode.sv */
// Address decoder of the tile bus: selects the slave, muxes its response, answers unmapped accesses
`include "tile_defines.svh"

module wb_slave_decode
   import tile_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_n_i,
   input  wb_req_t bus_req_i,
   output wb_rsp_t bus_rsp_o,
   output wb_req_t dm_req_o,
   input  wb_rsp_t dm_rsp_i,
   output wb_req_t boot_req_o,
   input  wb_rsp_t boot_rsp_i,
   output snoop_t  snoop_o
);

   slave_sel_e slv_sel;
   logic       err_q;   // Error response for unmapped addresses

   always_comb begin
      if (!bus_req_i.adr.view.region[3]) begin
         slv_sel = SLV_DM;                   // Lower half is data memory
      end else if (bus_req_i.adr.view.region == `TILE_REGION_BOOT) begin
         slv_sel = SLV_BOOT;
      end else begin
         slv_sel = SLV_NONE;
      end
   end

   // Strobe goes to the selected slave only
   always_comb begin
      dm_req_o       = bus_req_i;
      dm_req_o.stb   = bus_req_i.stb && (slv_sel == SLV_DM);
      boot_req_o     = bus_req_i;
      boot_req_o.stb = bus_req_i.stb && (slv_sel == SLV_BOOT);
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= bus_req_i.cyc && bus_req_i.stb && (slv_sel == SLV_NONE) && !err_q;
      end
   end

   // Address is held until the response, so the select still points at the right slave
   always_comb begin
      case (slv_sel)
         SLV_DM:   bus_rsp_o = dm_rsp_i;
         SLV_BOOT: bus_rsp_o = boot_rsp_i;
         default:  bus_rsp_o = '{ack: 1'b0, err: err_q, dat: '0};
      endcase
   end

   // Coherence hint for caches on every completed memory write
   assign snoop_o.valid = dm_rsp_i.ack && bus_req_i.we;
   assign snoop_o.adr   = bus_req_i.adr.raw;

   // A slave answer reaches the bus as exactly one of ack or err
   a_ack_err_excl : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (dm_rsp_i.ack || boot_rsp_i.ack || err_q) |-> (bus_rsp_o.ack ^ bus_rsp_o.err));

endmodule

/* hdl/wb_sram.sv */
// Single-port local data memory on the tile bus, byte writable, aliased over its address region
`include "tile_defines.svh"

module wb_sram
   import tile_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_n_i,
   input  wb_req_t req_i,
   output wb_rsp_t rsp_o
);

   localparam int IDX_W = $clog2(`TILE_LMEM_WORDS);

   logic [`TILE_DATA_W-1:0] mem [`TILE_LMEM_WORDS];
   logic [IDX_W-1:0]        idx;
   logic                    access;
   logic                    ack_q;
   logic [`TILE_DATA_W-1:0] dat_q;

   assign idx    = req_i.adr.raw[IDX_W+1:2];  // Word index, upper bits alias
   assign access = req_i.cyc && req_i.stb && !ack_q;

   // Ack cycle is skipped so a held strobe does not start a second access
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   always_ff @(posedge clk_i) begin
      if (access) begin
         if (req_i.we) begin
            for (int b = 0; b < `TILE_SEL_W; b++) begin
               if (req_i.sel[b]) begin
                  mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
               end
            end
         end
         dat_q <= mem[idx];
      end
   end

   assign rsp_o.ack = ack_q;
   assign rsp_o.err = 1'b0;
   assign rsp_o.dat = dat_q;

   // Request must still be up and unchanged while the ack is on the bus
   a_ack_after_stb : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rsp_o.ack |-> $past(req_i.stb) && req_i.stb && $stable(req_i.adr.raw));

endmodule

/* hdl/boot_rom.sv */
// Read-only boot memory of the tile, answering bus reads from the built-in boot image
`include "tile_defines.svh"
`include "boot_rom_image.svh"

module boot_rom
   import tile_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_n_i,
   input  wb_req_t req_i,
   output wb_rsp_t rsp_o
);

   localparam int IDX_W = $clog2(`TILE_BOOT_WORDS);
   localparam logic [`TILE_DATA_W-1:0] ROM [`TILE_BOOT_WORDS] = `BOOT_IMAGE;

   logic [IDX_W-1:0]        idx;
   logic                    access;
   logic                    ack_q;
   logic [`TILE_DATA_W-1:0] dat_q;

   assign idx    = req_i.adr.raw[IDX_W+1:2];  // Wraps every 64 bytes
   assign access = req_i.cyc && req_i.stb && !ack_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;   // Writes get acked too, content stays
      end
   end

   always_ff @(posedge clk_i) begin
      if (access) begin
         dat_q <= ROM[idx];
      end
   end

   assign rsp_o.ack = ack_q;
   assign rsp_o.err = 1'b0;
   assign rsp_o.dat = dat_q;

endmodule

/* hdl/compute_tile.sv */
// Top level of the compute tile bus fabric, connecting two masters to data memory and boot ROM
`include "tile_defines.svh"

module compute_tile
   import tile_pkg::*;
(
   input  logic                         clk_i,
   input  logic                         rst_n_i,
   input  wb_req_t [`TILE_MASTERS-1:0]  m_req_i,
   output wb_rsp_t [`TILE_MASTERS-1:0]  m_rsp_o,
   output snoop_t                       snoop_o
);

   wb_req_t bus_req;    // Owner's request
   wb_rsp_t bus_rsp;
   wb_req_t dm_req;
   wb_rsp_t dm_rsp;
   wb_req_t boot_req;
   wb_rsp_t boot_rsp;

   wb_arbiter #(
      .MASTERS (`TILE_MASTERS)
   ) u_wb_arbiter (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .m_req_i   (m_req_i),
      .m_rsp_o   (m_rsp_o),
      .bus_req_o (bus_req),
      .bus_rsp_i (bus_rsp)
   );

   wb_slave_decode u_wb_slave_decode (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .bus_req_i  (bus_req),
      .bus_rsp_o  (bus_rsp),
      .dm_req_o   (dm_req),
      .dm_rsp_i   (dm_rsp),
      .boot_req_o (boot_req),
      .boot_rsp_i (boot_rsp),
      .snoop_o    (snoop_o)
   );

   // Local data memory, 0x00000000 to 0x7fffffff
   wb_sram u_wb_sram (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (dm_req),
      .rsp_o   (dm_rsp)
   );

   // Boot ROM, 0xf0000000 to 0xffffffff
   boot_rom u_boot_rom (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (boot_req),
      .rsp_o   (boot_rsp)
   );

endmodule

/* testbench/tb_clock.sv */
// Free-running testbench clock for the compute tile testbench, starts low, 40 time units per period
module tb_clock #(
   parameter int PERIOD = 40
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD / 2) clk_o = ~clk_o;  // Half period per toggle
      end
   end

endmodule

/* testbench/tb_compute_tile.sv */
// Random testbench of the compute tile; drives both masters and checks responses against a model
`include "tile_defines.svh"
`include "boot_rom_image.svh"

module tb_compute_tile
   import tile_pkg::*;
();

   localparam int timeout_cycles = 20;
   localparam int pair_ops       = 16;
   localparam logic [`TILE_DATA_W-1:0] boot_table [`TILE_BOOT_WORDS] = `BOOT_IMAGE;

   logic                        clk;
   logic                        rst_n;
   wb_req_t [`TILE_MASTERS-1:0] m_req;
   wb_rsp_t [`TILE_MASTERS-1:0] m_rsp;
   snoop_t                      snoop;

   logic [15:0]             lfsr;
   logic [`TILE_DATA_W-1:0] model_mem [`TILE_LMEM_WORDS];  // Expected data memory
   logic                    op_we  [`TILE_MASTERS][pair_ops];
   logic [3:0]              op_sel [`TILE_MASTERS][pair_ops];
   logic [31:0]             op_adr [`TILE_MASTERS][pair_ops];
   logic [31:0]             op_dat [`TILE_MASTERS][pair_ops];
   string                   test_name;
   int                      test_errs;
   int                      tests_run;
   int                      tests_failed;
   int                      stray;       // Responses seen with no cycle open
   int                      stray_seen;

   tb_clock u_tb_clock (
      .clk_o (clk)
   );

   compute_tile u_compute_tile (
      .clk_i   (clk),
      .rst_n_i (rst_n),
      .m_req_i (m_req),
      .m_rsp_o (m_rsp),
      .snoop_o (snoop)
   );

   // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   // Lower half with random alias bits above the word index
   function automatic logic [31:0] dm_addr(input logic [7:0] widx);
      return {1'b0, 21'(rand_bits(21)), widx, 2'b00};
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  sel);
      logic [31:0] w;
      w = old_w;
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) begin
            w[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return w;
   endfunction

   task automatic check_rsp(input string what, input wb_rsp_t exp, input wb_rsp_t act,
                            input logic chk_dat);
      if (act.ack !== exp.ack || act.err !== exp.err || (chk_dat && act.dat !== exp.dat)) begin
         $display("Fail %s expected ack=%0b err=%0b dat=%h actual ack=%0b err=%0b dat=%h",
                  what, exp.ack, exp.err, exp.dat, act.ack, act.err, act.dat);
         test_errs++;
      end
   endtask

   task automatic check_snoop(input string what, input snoop_t exp, input snoop_t act);
      if (act.valid !== exp.valid || (exp.valid && act.adr !== exp.adr)) begin
         $display("Fail %s expected snoop valid=%0b adr=%h actual valid=%0b adr=%h",
                  what, exp.valid, exp.adr, act.valid, act.adr);
         test_errs++;
      end
   endtask

   // Called at the drive point, returns at the drive point after one idle cycle
   task automatic bus_access(input int m, input wb_req_t req, output wb_rsp_t rsp,
                             output snoop_t snp, output int n_snoop, output bit done);
      int cnt;
      rsp     = '0;
      snp     = '0;
      n_snoop = 0;
      done    = 1'b0;
      cnt     = 0;
      m_req[m] = req;
      while (!done && cnt < timeout_cycles) begin
         @(posedge clk);
         #1;
         cnt++;
         if (snoop.valid) begin
            n_snoop++;
         end
         if (m_rsp[m].ack || m_rsp[m].err) begin
            rsp  = m_rsp[m];
            snp  = snoop;   // Snoop belongs to the acked owner
            done = 1'b1;
         end
      end
      @(posedge clk);
      #5;
      m_req[m] = '0;      // Request stays up through the ack cycle
      @(posedge clk);
      #5;
   endtask

   // One access with expected response from the address map and the model
   task automatic do_access(input int m, input logic we, input logic [3:0] sel,
                            input logic [31:0] adr, input logic [31:0] dat, input bit solo);
      wb_req_t    req;
      wb_rsp_t    exp_rsp;
      wb_rsp_t    act_rsp;
      snoop_t     exp_snp;
      snoop_t     act_snp;
      int         n_snoop;
      bit         done;
      logic [7:0] widx;
      req         = '0;
      req.cyc     = 1'b1;
      req.stb     = 1'b1;
      req.we      = we;
      req.sel     = sel;
      req.adr.raw = adr;
      req.dat     = dat;
      exp_rsp     = '0;
      exp_snp     = '0;
      widx        = adr[9:2];
      if (!adr[31]) begin
         exp_rsp.ack   = 1'b1;
         exp_rsp.dat   = model_mem[widx];
         exp_snp.valid = we;
         exp_snp.adr   = adr;
      end else if (adr[31:28] == `TILE_REGION_BOOT) begin
         exp_rsp.ack = 1'b1;
         exp_rsp.dat = boot_table[adr[5:2]];  // Image wraps every 64 bytes
      end else begin
         exp_rsp.err = 1'b1;
      end
      bus_access(m, req, act_rsp, act_snp, n_snoop, done);
      if (!done) begin
         $display("%s: master %0d saw no ack or err within %0d cycles at address %h",
                  test_name, m, timeout_cycles, adr);
         test_errs++;
      end else begin
         check_rsp(test_name, exp_rsp, act_rsp, !we && exp_rsp.ack);
         check_snoop(test_name, exp_snp, act_snp);
         if (solo && n_snoop != int'(exp_snp.valid)) begin
            $display("Fail %s expected %0d snoop pulses actual %0d",
                     test_name, int'(exp_snp.valid), n_snoop);
            test_errs++;
         end
      end
      if (we && !adr[31]) begin
         model_mem[widx] = merge_bytes(model_mem[widx], dat, sel);
      end
   endtask

   task automatic run_ops(input int m);
      for (int k = 0; k < pair_ops; k++) begin
         do_access(m, op_we[m][k], op_sel[m][k], op_adr[m][k], op_dat[m][k], 1'b0);
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errs = 0;
   endtask

   task automatic end_test();
      if (stray != stray_seen) begin
         $display("%s: %0d responses reached a master that had no cycle open",
                  test_name, stray - stray_seen);
         test_errs += stray - stray_seen;
         stray_seen = stray;
      end
      tests_run++;
      if (test_errs == 0) begin
         $display("Test %s finished with no errors", test_name);
      end else begin
         $display("Test %s finished with %0d errors", test_name, test_errs);
         tests_failed++;
      end
   endtask

   // Catches an ack or err that arrives outside an open cycle
   always begin
      @(posedge clk);
      #1;
      for (int m = 0; m < `TILE_MASTERS; m++) begin
         if (rst_n && (m_rsp[m].ack || m_rsp[m].err) && !m_req[m].cyc) begin
            stray++;
         end
      end
   end

   initial begin
      logic [31:0] adr;
      logic [3:0]  reg_n;
      logic [1:0]  kind;
      lfsr         = 16'd56953;
      rst_n        = 1'b0;
      m_req        = '0;
      test_errs    = 0;
      tests_run    = 0;
      tests_failed = 0;
      stray        = 0;
      stray_seen   = 0;
      repeat (16) @(posedge clk);
      #5;
      rst_n = 1'b1;

      start_test("reset");
      repeat (8) begin
         @(posedge clk);
         #1;
         for (int m = 0; m < `TILE_MASTERS; m++) begin
            check_rsp("reset", '0, m_rsp[m], 1'b0);
         end
         check_snoop("reset", '0, snoop);
         #4;
      end
      end_test();

      start_test("dm_fill");
      for (int i = 0; i < `TILE_LMEM_WORDS; i++) begin
         do_access(i % 2, 1'b1, 4'hf, dm_addr(8'(i)), rand_bits(32), 1'b1);
      end
      end_test();

      start_test("dm_random");
      for (int i = 0; i < 40; i++) begin
         adr = dm_addr(8'(rand_bits(8)));
         do_access(i % 2, 1'b1, 4'(rand_bits(4)), adr, rand_bits(32), 1'b1);
         do_access((i + 1) % 2, 1'b0, 4'hf, dm_addr(adr[9:2]), '0, 1'b1);  // Alias read
         do_access(i % 2, 1'b0, 4'hf, dm_addr(8'(rand_bits(8))), '0, 1'b1);
      end
      end_test();

      start_test("boot_rom");
      for (int i = 0; i < 12; i++) begin
         do_access(i % 2, 1'b0, 4'hf, {4'hf, 28'(rand_bits(28))}, '0, 1'b1);
      end
      for (int i = 0; i < 4; i++) begin
         adr = {4'hf, 28'(rand_bits(28))};
         do_access(0, 1'b1, 4'hf, adr, rand_bits(32), 1'b1);
         do_access(1, 1'b0, 4'hf, adr, '0, 1'b1);
      end
      end_test();

      start_test("unmapped");
      for (int i = 0; i < 10; i++) begin
         reg_n = 4'(8 + rand_bits(3) % 7);  // Region 8 to e
         adr   = {reg_n, 28'(rand_bits(28))};
         do_access(i % 2, 1'(rand_bits(1)), 4'(rand_bits(4)), adr, rand_bits(32), 1'b1);
         do_access(i % 2, 1'b0, 4'hf, dm_addr(8'(rand_bits(8))), '0, 1'b1);
      end
      end_test();

      // Each master keeps to its own half of the data memory
      start_test("two_masters");
      for (int m = 0; m < `TILE_MASTERS; m++) begin
         for (int k = 0; k < pair_ops; k++) begin
            kind           = 2'(rand_bits(2));
            op_we[m][k]    = (kind < 2'd2);
            op_sel[m][k]   = 4'(rand_bits(4));
            op_dat[m][k]   = rand_bits(32);
            op_adr[m][k]   = dm_addr({1'(m), 7'(rand_bits(7))});
            if (kind == 2'd3) begin
               op_adr[m][k] = {4'hf, 28'(rand_bits(28))};
            end
         end
      end
      fork
         run_ops(0);
         run_ops(1);
      join
      end_test();

      $display("%0d tests run, %0d failed", tests_run, tests_failed);
      if (tests_failed == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* build.f */
+incdir+hdl
hdl/tile_pkg.sv
hdl/wb_arbiter.sv
hdl/wb_slave_decode.sv
hdl/wb_sram.sv
hdl/boot_rom.sv
hdl/compute_tile.sv
testbench/tb_clock.sv
testbench/tb_compute_tile.sv

/* run_sim.sh */
#!/bin/sh
# Compiles the compute tile testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_compute_tile

out=$(./obj_dir/Vtb_compute_tile)
echo "$out"

# Exit status follows the testbench result
echo "$out" | grep -q "Regression passed"
